/* controlUnit_golden.txt */
// columns: test name, instruction word (hex), flags carry zero negative (binary),
// expected {regCtrl, aluCtrl, memCtrl, fetchCtrl} packed into 30 bits (hex)
nop        0000 000 00100407
aluImm     35A5 000 03988C07
ldi        5C31 000 05980407
aluReg     2728 000 07914C07
out        4214 000 041004C7
inExec     63C2 000 261004A4
inWait     63C2 000 269004A7
pushSr     00C8 000 0E234447
popSr      00D0 000 0E436C27
setSr      05D8 000 00049C07
clrSr      03E0 000 00045C07
storeInc   9470 000 04534447
loadExec   1390 000 22134424
loadWait   1390 000 22B34427
pairInc    0698 000 06534407
pairJmp    08A8 000 08134413
jmpAlwExec 00B0 000 00034404
jmpAlwTgt  00B0 000 0003440F
jmpCExec   20B0 100 02034404
jmpCTgt    20B0 100 0203440F
jmpCSkip   20B0 000 02034403
jmpNcExec  40B0 000 04034404
jmpNcTgt   40B0 000 0403440F
jmpNcSkip  40B0 100 04034403
jmpZExec   60B0 010 06034404
jmpZTgt    60B0 010 0603440F
jmpZSkip   60B0 000 06034403
jmpNzSkip  80B0 010 08034403
jmpNzExec  80B0 000 08034404
jmpNzTgt   80B0 000 0803440F
jmpNExec   A0B0 001 0A034404
jmpNTgt    A0B0 001 0A03440F
jmpNSkip   A0B0 000 0A034403
jmpNnSkip  C0B0 001 0C034403
jmpNnExec  C0B0 000 0C034404
jmpNnTgt   C0B0 000 0C03440F
callLow    60B8 010 0E300244
callHigh   60B8 010 0E30004F
callSkip   60B8 000 0E100203
retExec    20C0 100 0E500534
retPop     20C0 100 0E500534
retFinal   20C0 100 0E100537
retSkip    20C0 000 0E100527
hlt1       00E8 000 00100404
hlt2       00E8 000 00100404
hlt3       00E8 000 00100404
nopResume  0000 000 00100407

/* tb.f */
+incdir+.
isaPkg.sv
ctrlPkg.sv
instrDecoder.sv
cycleSequencer.sv
controlWordGen.sv
controlUnit.sv
ctrlChecker.sv
tbControlUnit.sv

/* tbControlUnit.sv */
`timescale 1ns/1ns

module tbControlUnit;
    import isaPkg::*;
    import ctrlPkg::*;

    localparam int clkPeriod = 40;
    localparam int slackCycles = 20;  // reset and drain margin

    logic         clk;
    logic         rstN;
    instrWord_t   instr;
    statusFlags_t flags;
    regFileCtrl_t regCtrl;
    aluCtrl_t     aluCtrl;
    memCtrl_t     memCtrl;
    fetchCtrl_t   fetchCtrl;

    logic         checkEn;
    logic [127:0] testName;
    logic [29:0]  expCtrl;  // {reg, alu, mem, fetch}
    int           errCount;
    int           vecCount;

    logic [127:0] nameQ[$];
    logic [15:0]  instrQ[$];
    logic [2:0]   flagsQ[$];
    logic [29:0]  expQ[$];
    int           numVec = 0;
    bit           loaded = 1'b0;

    controlUnit i_controlUnit (
        .clk       (clk),
        .rstN      (rstN),
        .instr     (instr),
        .flags     (flags),
        .regCtrl   (regCtrl),
        .aluCtrl   (aluCtrl),
        .memCtrl   (memCtrl),
        .fetchCtrl (fetchCtrl)
    );

    ctrlChecker i_ctrlChecker (
        .clk       (clk),
        .checkEn   (checkEn),
        .testName  (testName),
        .expCtrl   (expCtrl),
        .regCtrl   (regCtrl),
        .aluCtrl   (aluCtrl),
        .memCtrl   (memCtrl),
        .fetchCtrl (fetchCtrl),
        .errCount  (errCount),
        .vecCount  (vecCount)
    );

    // one vector per line, comment lines start with a slash
    task loadGolden();
        int           fd;
        int           n;
        string        line;
        logic [127:0] name;
        logic [15:0]  word;
        logic [2:0]   flg;
        logic [29:0]  exp;
        fd = $fopen("controlUnit_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open the golden vector file controlUnit_golden.txt");
        end else begin
            while ($fgets(line, fd) > 0) begin
                if (line.len() > 1 && line.getc(0) != 8'h2f) begin
                    n = $sscanf(line, "%s %h %b %h", name, word, flg, exp);
                    if (n == 4) begin
                        nameQ.push_back(name);
                        instrQ.push_back(word);
                        flagsQ.push_back(flg);
                        expQ.push_back(exp);
                    end
                end
            end
            $fclose(fd);
            numVec = expQ.size();
            if (numVec == 0) begin
                $display("no vectors found in the golden vector file");
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    initial begin
        rstN     = 1'b0;
        instr    = '0;
        flags    = '0;
        checkEn  = 1'b0;
        testName = '0;
        expCtrl  = '0;
        loadGolden();
        loaded = 1'b1;
        repeat (5) @(posedge clk);
        rstN <= 1'b1;
        for (int i = 0; i < numVec; i++) begin
            @(posedge clk);
            instr    <= instrWord_t'(instrQ[i]);
            flags    <= statusFlags_t'(flagsQ[i]);
            testName <= nameQ[i];
            expCtrl  <= expQ[i];
            checkEn  <= 1'b1;
        end
        @(posedge clk);
        checkEn <= 1'b0;
        instr   <= '0;  // back to NOP
        @(negedge clk);
        $display("errors: %0d, vectors checked: %0d of %0d", errCount, vecCount, numVec);
        if (errCount == 0 && vecCount == numVec && numVec > 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // limit scales with the number of vectors
    initial begin
        wait (loaded);
        #((numVec + slackCycles) * clkPeriod);
        $display("timeout: the run did not finish within %0d clock cycles",
                 numVec + slackCycles);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

/* ctrlChecker.sv */
`timescale 1ns/1ns

module ctrlChecker (
    input  logic                  clk,
    input  logic                  checkEn,
    input  logic [127:0]          testName,
    input  logic [29:0]           expCtrl,
    input  ctrlPkg::regFileCtrl_t regCtrl,
    input  ctrlPkg::aluCtrl_t     aluCtrl,
    input  ctrlPkg::memCtrl_t     memCtrl,
    input  ctrlPkg::fetchCtrl_t   fetchCtrl,
    output int                    errCount,
    output int                    vecCount
);
    logic [29:0] actCtrl;
    int          errs = 0;
    int          vecs = 0;

    assign actCtrl  = {regCtrl, aluCtrl, memCtrl, fetchCtrl};
    assign errCount = errs;
    assign vecCount = vecs;

    // names the control groups that differ
    function automatic string diffGroups(logic [29:0] e, logic [29:0] a);
        string s;
        s = "";
        if (e[29:21] != a[29:21]) s = {s, " reg"};
        if (e[20:11] != a[20:11]) s = {s, " alu"};
        if (e[10:5] != a[10:5]) s = {s, " mem"};
        if (e[4:0] != a[4:0]) s = {s, " fetch"};
        return s;
    endfunction

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        if (checkEn) begin
            vecs = vecs + 1;
            if ($isunknown(actCtrl)) begin
                errs = errs + 1;
                $display("control outputs hold unknown bits during test %0s", testName);
            end else if (actCtrl !== expCtrl) begin
                errs = errs + 1;
                $display("ERR %0s: expected %h, actual %h, groups:%0s",
                         testName, expCtrl, actCtrl, diffGroups(expCtrl, actCtrl));
            end
        end
    end

endmodule

/* controlUnit.sv */
`timescale 1ns/1ns

module controlUnit (
    input  logic                  clk,
    input  logic                  rstN,
    input  isaPkg::instrWord_t    instr,
    input  ctrlPkg::statusFlags_t flags,
    output ctrlPkg::regFileCtrl_t regCtrl,
    output ctrlPkg::aluCtrl_t     aluCtrl,
    output ctrlPkg::memCtrl_t     memCtrl,
    output ctrlPkg::fetchCtrl_t   fetchCtrl
);
    import isaPkg::*;
    import ctrlPkg::*;

    instrClass_e instrClass;
    decFields_t  decFields;
    logic        condMet;
    seqPhase_e   phase;

    instrDecoder i_instrDecoder (
        .instr      (instr),
        .flags      (flags),
        .instrClass (instrClass),
        .decFields  (decFields),
        .condMet    (condMet)
    );

    cycleSequencer i_cycleSequencer (
        .clk        (clk),
        .rstN       (rstN),
        .instrClass (instrClass),
        .condMet    (condMet),
        .phase      (phase)
    );

    controlWordGen i_controlWordGen (
        .instrClass (instrClass),
        .decFields  (decFields),
        .condMet    (condMet),
        .phase      (phase),
        .regCtrl    (regCtrl),
        .aluCtrl    (aluCtrl),
        .memCtrl    (memCtrl),
        .fetchCtrl  (fetchCtrl)
    );

endmodule

/* controlWordGen.sv */
`timescale 1ns/1ns
`include "cpuCtrl_consts.svh"

module controlWordGen (
    input  isaPkg::instrClass_e   instrClass,
    input  isaPkg::decFields_t    decFields,
    input  logic                  condMet,
    input  ctrlPkg::seqPhase_e    phase,
    output ctrlPkg::regFileCtrl_t regCtrl,
    output ctrlPkg::aluCtrl_t     aluCtrl,
    output ctrlPkg::memCtrl_t     memCtrl,
    output ctrlPkg::fetchCtrl_t   fetchCtrl
);
    import isaPkg::*;
    import ctrlPkg::*;

    logic stall;  // non-final cycle or halt

    always_comb begin
        stall     = 1'b0;
        regCtrl   = '{src: RS_ALU, bSel: decFields.destSel, write: 1'b0,
                      incPair: 1'b0, decPair: 1'b0};
        aluCtrl   = '{aSelReg: 1'b1, bSel: BS_REG, mode: `ALU_PASS_B,
                      statusSrc: SS_ALU_FLAGS, flagEn: 1'b0};
        memCtrl   = '{dataSel: MD_ALU, addrSel: MA_PAIR, write: 1'b0, read: 1'b0};
        fetchCtrl = '{addrSel: FA_PC, readEn: 1'b1, pcWrite: 1'b1};

        case (instrClass)
            CL_ALU_IMM, CL_LDI: begin
                regCtrl.write  = 1'b1;
                aluCtrl.bSel   = BS_IMM;
                aluCtrl.mode   = decFields.aluMode;
                aluCtrl.flagEn = (instrClass == CL_ALU_IMM);  // LDI leaves flags
            end
            CL_IN: begin
                regCtrl.src     = RS_MEM;
                regCtrl.write   = (phase == PH_IO_WAIT);
                memCtrl.addrSel = MA_PORT;
                memCtrl.read    = 1'b1;
                stall           = (phase == PH_EXEC);
            end
            CL_OUT: begin
                memCtrl.addrSel = MA_PORT;  // register passes through B
                memCtrl.write   = 1'b1;
            end
            CL_ALU_REG: begin
                regCtrl.bSel   = decFields.srcSel;
                regCtrl.write  = 1'b1;
                aluCtrl.mode   = decFields.aluMode;
                aluCtrl.flagEn = 1'b1;
            end
            CL_STORE: begin
                regCtrl.bSel    = decFields.pairSel;
                regCtrl.incPair = decFields.pairInc;
                regCtrl.decPair = decFields.pairDec;
                aluCtrl.mode    = `ALU_PASS_A;
                memCtrl.write   = 1'b1;
            end
            CL_LOAD: begin
                regCtrl.src  = RS_MEM;
                regCtrl.bSel = decFields.pairSel;
                aluCtrl.mode = `ALU_PASS_A;
                memCtrl.read = 1'b1;
                if (phase == PH_LOAD_WAIT) begin
                    regCtrl.write   = 1'b1;
                    regCtrl.incPair = decFields.pairInc;
                    regCtrl.decPair = decFields.pairDec;
                end else begin
                    stall = 1'b1;
                end
            end
            CL_PAIR_INC, CL_PAIR_DEC, CL_PAIR_JMP: begin
                regCtrl.bSel    = decFields.pairSel;
                regCtrl.incPair = (instrClass == CL_PAIR_INC);
                regCtrl.decPair = (instrClass == CL_PAIR_DEC);
                aluCtrl.mode    = `ALU_PASS_A;
                if (instrClass == CL_PAIR_JMP && condMet) begin
                    fetchCtrl.addrSel = FA_PAIR;
                end
            end
            CL_JMP: begin
                aluCtrl.aSelReg = 1'b0;
                aluCtrl.mode    = `ALU_PASS_A;
                if (phase == PH_JMP_TARGET) begin
                    fetchCtrl.addrSel = FA_FETCHED;
                end else if (condMet) begin
                    stall = 1'b1;  // target word read at PC
                end else begin
                    fetchCtrl.addrSel = FA_PC_PLUS1;  // skip the target word
                end
            end
            CL_CALL: begin
                regCtrl.bSel    = `SP_LOW_REG;
                memCtrl.dataSel = MD_PC_LOW;
                if (phase == PH_CALL_HIGH) begin
                    regCtrl.decPair   = 1'b1;
                    memCtrl.dataSel   = MD_PC_HIGH;
                    memCtrl.write     = 1'b1;
                    fetchCtrl.addrSel = FA_FETCHED;
                end else if (condMet) begin
                    regCtrl.decPair = 1'b1;
                    memCtrl.write   = 1'b1;
                    stall           = 1'b1;
                end else begin
                    fetchCtrl.addrSel = FA_PC_PLUS1;
                end
            end
            CL_RET: begin
                regCtrl.bSel    = `SP_LOW_REG;
                memCtrl.addrSel = MA_PAIR_PLUS1;
                memCtrl.read    = 1'b1;
                if (phase == PH_RET_FINAL) begin
                    fetchCtrl.addrSel = FA_RETURN;
                end else if (phase == PH_RET_POP || condMet) begin
                    regCtrl.incPair   = 1'b1;
                    fetchCtrl.addrSel = FA_RETURN;
                    stall             = 1'b1;
                end
            end
            CL_PUSH_SR: begin
                regCtrl.bSel    = `SP_LOW_REG;
                regCtrl.decPair = 1'b1;
                aluCtrl.aSelReg = 1'b0;
                aluCtrl.mode    = `ALU_PASS_A;
                memCtrl.write   = 1'b1;
            end
            CL_POP_SR: begin
                regCtrl.bSel      = `SP_LOW_REG;
                regCtrl.incPair   = 1'b1;
                aluCtrl.aSelReg   = 1'b0;
                aluCtrl.mode      = `ALU_PASS_A;
                aluCtrl.statusSrc = SS_POPPED;
                aluCtrl.flagEn    = 1'b1;
                memCtrl.read      = 1'b1;
            end
            CL_SET_SR, CL_CLR_SR: begin
                aluCtrl.aSelReg   = 1'b0;
                aluCtrl.bSel      = BS_MASK;
                aluCtrl.mode      = (instrClass == CL_SET_SR) ? `ALU_OR : `ALU_AND;
                aluCtrl.statusSrc = SS_ALU_OUT;
                aluCtrl.flagEn    = 1'b1;
            end
            CL_HLT:  stall = 1'b1;
            default: stall = 1'b0;  // NOP keeps the idle word
        endcase

        if (stall) begin
            fetchCtrl.readEn  = 1'b0;
            fetchCtrl.pcWrite = 1'b0;
        end
    end

endmodule

/* cycleSequencer.sv */
`timescale 1ns/1ns

module cycleSequencer (
    input  logic                clk,
    input  logic                rstN,
    input  isaPkg::instrClass_e instrClass,
    input  logic                condMet,
    output ctrlPkg::seqPhase_e  phase
);
    import isaPkg::*;
    import ctrlPkg::*;

    seqPhase_e nextPhase;

    always_comb begin
        nextPhase = PH_EXEC;
        case (phase)
            PH_EXEC: begin
                case (instrClass)
                    CL_IN:   nextPhase = PH_IO_WAIT;
                    CL_LOAD: nextPhase = PH_LOAD_WAIT;
                    CL_JMP: begin
                        if (condMet) nextPhase = PH_JMP_TARGET;
                    end
                    CL_CALL: begin
                        if (condMet) nextPhase = PH_CALL_HIGH;
                    end
                    CL_RET: begin
                        if (condMet) nextPhase = PH_RET_POP;
                    end
                    default: nextPhase = PH_EXEC;
                endcase
            end
            PH_RET_POP: nextPhase = PH_RET_FINAL;  // second stack byte
            default:    nextPhase = PH_EXEC;       // every other phase is final
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            phase <= PH_EXEC;
        end else begin
            phase <= nextPhase;
        end
    end

endmodule

/* instrDecoder.sv */
`timescale 1ns/1ns
`include "cpuCtrl_consts.svh"

module instrDecoder (
    input  isaPkg::instrWord_t    instr,
    input  ctrlPkg::statusFlags_t flags,
    output isaPkg::instrClass_e   instrClass,
    output isaPkg::decFields_t    decFields,
    output logic                  condMet
);
    import isaPkg::*;

    logic [`FUNC_W-1:0] func;
    condCode_e          cond;

    assign func = instr.regForm.func;
    assign cond = condCode_e'(instr.regForm.dest[`REG_SEL_W-1:1]);  // top three bits

    always_comb begin
        instrClass = CL_NOP;
        if (instr.immForm.immFlag && instr.immForm.aluOp < `IMM_OP_LIMIT) begin
            instrClass = (instr.immForm.aluOp == '0) ? CL_LDI : CL_ALU_IMM;
        end else if (instr.ioForm.cls[`CLS_W-1:0] == `CLS_IN) begin
            instrClass = CL_IN;
        end else if (instr.ioForm.cls[`CLS_W-1:0] == `CLS_OUT) begin
            instrClass = CL_OUT;
        end else if (instr.regForm.cls == `CLS_REG) begin
            case (func) inside
                [`FN_ALU_LO:`FN_ALU_HI]: instrClass = CL_ALU_REG;
                [`FN_ST:`FN_ST_DEC]:     instrClass = CL_STORE;
                [`FN_LD:`FN_LD_DEC]:     instrClass = CL_LOAD;
                `FN_PAIR_INC:            instrClass = CL_PAIR_INC;
                `FN_PAIR_DEC:            instrClass = CL_PAIR_DEC;
                `FN_PAIR_JMP:            instrClass = CL_PAIR_JMP;
                `FN_JMP:                 instrClass = CL_JMP;
                `FN_CALL:                instrClass = CL_CALL;
                `FN_RET:                 instrClass = CL_RET;
                `FN_PUSH_SR:             instrClass = CL_PUSH_SR;
                `FN_POP_SR:              instrClass = CL_POP_SR;
                `FN_SET_SR:              instrClass = CL_SET_SR;
                `FN_CLR_SR:              instrClass = CL_CLR_SR;
                `FN_HLT:                 instrClass = CL_HLT;
                default:                 instrClass = CL_NOP;
            endcase
        end
    end

    always_comb begin
        decFields.destSel = instr.regForm.dest;
        decFields.srcSel  = instr.regForm.src;
        decFields.pairSel = {instr.regForm.src[`REG_SEL_W-1:1], 1'b0};
        if (instr.immForm.immFlag) begin
            decFields.aluMode = {1'b0, instr.immForm.aluOp};
        end else begin
            decFields.aluMode = func[`ALU_MODE_W-1:0];
        end
        decFields.pairInc = (func == `FN_ST_INC) || (func == `FN_LD_INC);
        decFields.pairDec = (func == `FN_ST_DEC) || (func == `FN_LD_DEC);
    end

    // jump, call and return condition
    always_comb begin
        case (cond)
            CC_CARRY:    condMet = flags.carry;
            CC_NO_CARRY: condMet = ~flags.carry;
            CC_ZERO:     condMet = flags.zero;
            CC_NO_ZERO:  condMet = ~flags.zero;
            CC_NEG:      condMet = flags.negative;
            CC_NO_NEG:   condMet = ~flags.negative;
            default:     condMet = 1'b1;
        endcase
    end

endmodule

/* ctrlPkg.sv */
`include "cpuCtrl_consts.svh"

package ctrlPkg;

    typedef struct packed {
        logic carry;
        logic zero;
        logic negative;
    } statusFlags_t;

    typedef enum logic [2:0] {
        PH_EXEC       = 3'd0,
        PH_IO_WAIT    = 3'd1,
        PH_LOAD_WAIT  = 3'd2,
        PH_JMP_TARGET = 3'd3,
        PH_CALL_HIGH  = 3'd4,
        PH_RET_POP    = 3'd5,
        PH_RET_FINAL  = 3'd6
    } seqPhase_e;

    typedef enum logic [1:0] {
        RS_ALU = 2'b00,
        RS_IMM = 2'b01,
        RS_MEM = 2'b10    // data memory or IO
    } regSrcSel_e;

    typedef enum logic [1:0] {
        BS_REG  = 2'b00,
        BS_MASK = 2'b01,  // 4-bit mask from the word
        BS_IMM  = 2'b10
    } aluBSel_e;

    typedef enum logic [1:0] {
        MD_PC_HIGH = 2'b00,
        MD_PC_LOW  = 2'b01,
        MD_ALU     = 2'b10
    } memDataSel_e;

    typedef enum logic [1:0] {
        MA_PAIR       = 2'b00,
        MA_PORT       = 2'b01,
        MA_PAIR_PLUS1 = 2'b10
    } memAddrSel_e;

    typedef enum logic [1:0] {
        SS_ALU_FLAGS = 2'b00,
        SS_ALU_OUT   = 2'b01,
        SS_POPPED    = 2'b10
    } statusSrcSel_e;

    typedef enum logic [2:0] {
        FA_PC_PLUS1 = 3'b000,
        FA_PC       = 3'b001,
        FA_FETCHED  = 3'b011,
        FA_PAIR     = 3'b100,
        FA_RETURN   = 3'b101  // return register and popped byte
    } fetchAddrSel_e;

    typedef struct packed {
        regSrcSel_e            src;
        logic [`REG_SEL_W-1:0] bSel;
        logic                  write;
        logic                  incPair;
        logic                  decPair;
    } regFileCtrl_t;

    typedef struct packed {
        logic                   aSelReg;  // low selects the status register
        aluBSel_e               bSel;
        logic [`ALU_MODE_W-1:0] mode;
        statusSrcSel_e          statusSrc;
        logic                   flagEn;
    } aluCtrl_t;

    typedef struct packed {
        memDataSel_e dataSel;
        memAddrSel_e addrSel;
        logic        write;
        logic        read;
    } memCtrl_t;

    typedef struct packed {
        fetchAddrSel_e addrSel;
        logic          readEn;
        logic          pcWrite;
    } fetchCtrl_t;

endpackage

/* isaPkg.sv */
`include "cpuCtrl_consts.svh"

package isaPkg;

    // one fetched word, read as register, immediate or IO form
    typedef union packed {
        struct packed {
            logic [`REG_SEL_W-1:0] dest;
            logic [`REG_SEL_W-1:0] src;
            logic [`FUNC_W-1:0]    func;
            logic [`CLS_W-1:0]     cls;
        } regForm;
        struct packed {
            logic [`REG_SEL_W-1:0] dest;
            logic [`IMM_W-1:0]     imm;
            logic [`ALU_OP_W-1:0]  aluOp;
            logic                  immFlag;
        } immForm;
        struct packed {
            logic [`REG_SEL_W-1:0] ioReg;
            logic [`PORT_W-1:0]    port;
            logic [`IO_CLS_W-1:0]  cls;
        } ioForm;
    } instrWord_t;

    typedef enum logic [4:0] {
        CL_NOP, CL_ALU_IMM, CL_LDI, CL_IN, CL_OUT, CL_ALU_REG,
        CL_STORE, CL_LOAD, CL_PAIR_INC, CL_PAIR_DEC, CL_PAIR_JMP,
        CL_JMP, CL_CALL, CL_RET, CL_PUSH_SR, CL_POP_SR,
        CL_SET_SR, CL_CLR_SR, CL_HLT
    } instrClass_e;

    // code 7 also means always
    typedef enum logic [`COND_W-1:0] {
        CC_ALWAYS   = 3'd0,
        CC_CARRY    = 3'd1,
        CC_NO_CARRY = 3'd2,
        CC_ZERO     = 3'd3,
        CC_NO_ZERO  = 3'd4,
        CC_NEG      = 3'd5,
        CC_NO_NEG   = 3'd6
    } condCode_e;

    typedef struct packed {
        logic [`REG_SEL_W-1:0]  destSel;
        logic [`REG_SEL_W-1:0]  srcSel;
        logic [`REG_SEL_W-1:0]  pairSel;   // even register of the pair
        logic [`ALU_MODE_W-1:0] aluMode;
        logic                   pairInc;   // post step of load/store
        logic                   pairDec;
    } decFields_t;

endpackage

/* cpuCtrl_consts.svh */
`ifndef CPU_CTRL_CONSTS_SVH
`define CPU_CTRL_CONSTS_SVH

`define INSTR_W      16
`define REG_SEL_W    4
`define FUNC_W       5
`define CLS_W        3
`define IO_CLS_W     4
`define ALU_OP_W     3
`define ALU_MODE_W   4
`define COND_W       3
`define IMM_W        8
`define PORT_W       (`INSTR_W - `REG_SEL_W - `IO_CLS_W)

`define SP_LOW_REG   4'd14

// class codes in the low bits of the word
`define CLS_REG      3'b000
`define CLS_IN       3'b010
`define CLS_OUT      3'b100
`define IMM_OP_LIMIT 3'd7

// function code boundaries of the register form
`define FN_ALU_LO    5'd1
`define FN_ALU_HI    5'd12
`define FN_ST        5'd13
`define FN_ST_INC    5'd14
`define FN_ST_DEC    5'd15
`define FN_LD        5'd16
`define FN_LD_INC    5'd17
`define FN_LD_DEC    5'd18
`define FN_PAIR_INC  5'd19
`define FN_PAIR_DEC  5'd20
`define FN_PAIR_JMP  5'd21
`define FN_JMP       5'd22
`define FN_CALL      5'd23
`define FN_RET       5'd24
`define FN_PUSH_SR   5'd25
`define FN_POP_SR    5'd26
`define FN_SET_SR    5'd27
`define FN_CLR_SR    5'd28
`define FN_HLT       5'd29

// ALU modes chosen directly by the control unit
`define ALU_PASS_B   4'd0
`define ALU_AND      4'd1
`define ALU_OR       4'd2
`define ALU_PASS_A   4'd13

`endif
